//--- rtl/bpsk_pkg.sv
package bpsk_pkg;

    // one carrier period is 2**PHASE_BITS samples, so the phase wraps for free
    localparam int PHASE_BITS      = 6;
    localparam int SAMPLES_PER_BIT = 2 ** PHASE_BITS;

    localparam int SAMPLE_WIDTH = 12;                            // DAC word width
    localparam logic [SAMPLE_WIDTH-1:0] MIDSCALE = 12'd2048;     // offset-binary zero
    localparam int PEAK = 2047;                                  // table amplitude

    typedef struct packed {
        logic                  valid;
        logic                  data_bit;
        logic [PHASE_BITS-1:0] index;
        logic                  last;     // final sample of the frame
    } seq_beat_t;

    // phase_mapper writes the raw address, sine_lookup decodes the quadrant
    typedef union packed {
        logic [PHASE_BITS-1:0] raw;
        struct packed {
            logic [1:0]            quadrant;  // top bit negative half, low bit mirrored
            logic [PHASE_BITS-3:0] offset;
        } field;
    } phase_word_u;

    typedef struct packed {
        logic        valid;
        logic        last;
        phase_word_u phase;
    } phase_beat_t;

endpackage

//--- rtl/frame_sequencer.sv
module frame_sequencer
    import bpsk_pkg::*;
#(
    parameter int DATA_SIZE = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 enable,
    input  logic [DATA_SIZE-1:0] data,
    output seq_beat_t            beat
);

    // a one bit frame still needs a counter of some width
    localparam int CNT_BITS = (DATA_SIZE > 1) ? $clog2(DATA_SIZE) : 1;

    logic                  enable_q;
    logic                  start;
    logic                  active;
    logic                  index_wrap;
    logic                  final_bit;
    logic [PHASE_BITS-1:0] index;
    logic [CNT_BITS-1:0]   bit_cnt;
    logic [DATA_SIZE-1:0]  shift_reg;

    assign start      = enable & ~enable_q;                      // enable rising edge
    assign index_wrap = (index == PHASE_BITS'(SAMPLES_PER_BIT - 1));
    assign final_bit  = (bit_cnt == CNT_BITS'(DATA_SIZE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable_q <= 1'b0;   // an enable already high at release counts as an edge
            active   <= 1'b0;
            index    <= '0;
            bit_cnt  <= '0;
        end else begin
            enable_q <= enable;
            if (start) begin
                active  <= 1'b1;
                index   <= '0;
                bit_cnt <= '0;
            end else if (active) begin
                if (!enable) begin
                    active <= 1'b0;                              // enable fell mid-frame so no done follows
                end else if (index_wrap && final_bit) begin
                    active <= 1'b0;
                end else begin
                    index <= index + 1'b1;                       // wraps to 0 after 63
                    if (index_wrap) begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // the word loads at the enable edge and shifts at every bit boundary
    always_ff @(posedge clk) begin
        if (start) begin
            shift_reg <= data;
        end else if (active && index_wrap) begin
            shift_reg <= shift_reg << 1;                         // next bit moves to the MSB
        end
    end

    always_comb begin
        beat.valid    = active;
        beat.data_bit = shift_reg[DATA_SIZE-1];
        beat.index    = index;
        beat.last     = active & index_wrap & final_bit;
    end

endmodule

//--- rtl/phase_mapper.sv
module phase_mapper
    import bpsk_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  seq_beat_t   beat,
    output phase_beat_t phased
);

    localparam logic [PHASE_BITS-1:0] HALF_PERIOD = PHASE_BITS'(SAMPLES_PER_BIT / 2);

    logic        valid_q;
    logic        last_q;
    phase_word_u next_phase;
    phase_word_u phase_q;

    // a 1 bit moves half a period on, the modulo add does the inversion
    always_comb begin
        next_phase.raw = beat.index + (beat.data_bit ? HALF_PERIOD : '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= beat.valid;
            last_q  <= beat.last;
        end
    end

    always_ff @(posedge clk) begin
        phase_q <= next_phase;
    end

    assign phased = '{valid: valid_q, last: last_q, phase: phase_q};

endmodule

//--- rtl/sine_lookup.sv
module sine_lookup
    import bpsk_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  phase_beat_t             phased,
    output logic [SAMPLE_WIDTH-1:0] sample_out,
    output logic                    done
);

    localparam int  QUARTER     = SAMPLES_PER_BIT / 4;
    localparam int  ENTRY_WIDTH = SAMPLE_WIDTH - 1;
    localparam int  ADDR_WIDTH  = PHASE_BITS - 1;                // reaches 16 for the peak
    localparam real PI          = 3.141592653589793;

    typedef logic [QUARTER:0][ENTRY_WIDTH-1:0] quarter_table_t;

    // first quarter of the sine, 17 entries so the peak has its own slot
    function automatic quarter_table_t build_quarter_table();
        quarter_table_t tbl;
        real            angle;
        tbl = '0;
        for (int k = 0; k <= QUARTER; k++) begin
            angle  = 2.0 * PI * real'(k) / real'(SAMPLES_PER_BIT);
            tbl[k] = ENTRY_WIDTH'($rtoi(real'(PEAK) * $sin(angle) + 0.5));
        end
        return tbl;
    endfunction

    localparam quarter_table_t SINE_TABLE = build_quarter_table();

    phase_word_u               phase;
    logic                      negative;
    logic                      mirrored;
    logic [ADDR_WIDTH-1:0]     offset;
    logic [ADDR_WIDTH-1:0]     addr;
    logic [ENTRY_WIDTH-1:0]    magnitude;
    logic [SAMPLE_WIDTH-1:0]   level;

    assign phase    = phased.phase;
    assign negative = phase.field.quadrant[1];   // second half of the period
    assign mirrored = phase.field.quadrant[0];   // falling quarter reads the table backwards
    assign offset   = {1'b0, phase.field.offset};

    assign addr      = mirrored ? (ADDR_WIDTH'(QUARTER) - offset) : offset;
    assign magnitude = SINE_TABLE[addr];

    always_comb begin
        if (negative) begin
            level = MIDSCALE - SAMPLE_WIDTH'(magnitude);
        end else begin
            level = MIDSCALE + SAMPLE_WIDTH'(magnitude);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_out <= MIDSCALE;
            done       <= 1'b0;
        end else begin
            // the output rests at midscale whenever no beat is valid
            sample_out <= phased.valid ? level : MIDSCALE;
            done       <= phased.valid & phased.last;   // lines up with the final sample
        end
    end

endmodule

//--- rtl/bpsk_modulator.sv
module bpsk_modulator
    import bpsk_pkg::*;
#(
    parameter int DATA_SIZE = 16
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    enable,
    input  logic [DATA_SIZE-1:0]    data,
    output logic [SAMPLE_WIDTH-1:0] sample_out,
    output logic                    done
);

    seq_beat_t   seq_beat;     // bit and sample index, cycles 1 to DATA_SIZE*64
    phase_beat_t phase_beat;

    frame_sequencer #(
        .DATA_SIZE(DATA_SIZE)
    ) i_frame_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .enable(enable),
        .data  (data),
        .beat  (seq_beat)
    );

    // one cycle for the phase add
    phase_mapper i_phase_mapper (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (seq_beat),
        .phased(phase_beat)
    );

    // one more cycle for the table read
    sine_lookup i_sine_lookup (
        .clk       (clk),
        .rst_n     (rst_n),
        .phased    (phase_beat),
        .sample_out(sample_out),
        .done      (done)
    );

endmodule

//--- dv/bpsk_modulator_properties.sv
module bpsk_modulator_properties
    import bpsk_pkg::*;
(
    input logic                    clk,
    input logic                    rst_n,
    input logic                    enable,
    input logic [SAMPLE_WIDTH-1:0] sample_out,
    input logic                    done
);

    timeunit 1ns;
    timeprecision 100ps;

    // every sample follows the reference model, idle periods included
    sample_follows_model: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_out == bpsk_modulator_tb.exp_sample
    ) else begin
        bpsk_modulator_tb.assert_errors = bpsk_modulator_tb.assert_errors + 1;
        $error("[ERROR] %0t sample_out: got %0d, expected %0d", $time,
               $sampled(sample_out), $sampled(bpsk_modulator_tb.exp_sample));
    end

    done_follows_model: assert property (
        @(posedge clk) disable iff (!rst_n)
        done == bpsk_modulator_tb.exp_done
    ) else begin
        bpsk_modulator_tb.assert_errors = bpsk_modulator_tb.assert_errors + 1;
        $error("[ERROR] %0t done: got %0b, expected %0b", $time,
               $sampled(done), $sampled(bpsk_modulator_tb.exp_done));
    end

    idle_midscale: assert property (
        @(posedge clk) disable iff (!rst_n)
        !bpsk_modulator_tb.out_valid |-> (sample_out == MIDSCALE)
    ) else begin
        bpsk_modulator_tb.assert_errors = bpsk_modulator_tb.assert_errors + 1;
        $error("[ERROR] %0t sample_out: got %0d, expected %0d", $time,
               $sampled(sample_out), MIDSCALE);
    end

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |=> !done
    ) else begin
        bpsk_modulator_tb.assert_errors = bpsk_modulator_tb.assert_errors + 1;
        $error("[ERROR] %0t done: got %0b, expected %0b", $time, $sampled(done), 1'b0);
    end

    // the sequencer stops one edge after enable falls, two more edges drain the pipeline
    abort_returns_midscale: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(enable) |-> ##3 (sample_out == MIDSCALE)
    ) else begin
        bpsk_modulator_tb.assert_errors = bpsk_modulator_tb.assert_errors + 1;
        $error("[ERROR] %0t sample_out: got %0d, expected %0d", $time,
               $sampled(sample_out), MIDSCALE);
    end

    inverted_words: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bpsk_modulator_tb.pair_check && bpsk_modulator_tb.out_valid) |->
            (13'(sample_out) + 13'(bpsk_modulator_tb.mirror_sample) == 13'd4096)
    ) else begin
        bpsk_modulator_tb.assert_errors = bpsk_modulator_tb.assert_errors + 1;
        $error("[ERROR] %0t sample_out: got %0d, expected %0d", $time, $sampled(sample_out),
               4096 - int'($sampled(bpsk_modulator_tb.mirror_sample)));
    end

endmodule

//--- dv/bpsk_modulator_tb.sv
module bpsk_modulator_tb
    import bpsk_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int  DATA_SIZE      = 8;                           // short frames keep runs quick
    localparam int  FRAME_BEATS    = DATA_SIZE * SAMPLES_PER_BIT;
    localparam int  FRAME_CYCLES   = FRAME_BEATS + 10;
    localparam int  ABORT_CYCLES   = 150;
    localparam int  TIMEOUT_CYCLES = 4 * FRAME_CYCLES + ABORT_CYCLES + 300;
    localparam real PI             = 3.141592653589793;

    logic                    clk;
    logic                    rst_n;
    logic                    enable;
    logic [DATA_SIZE-1:0]    data;
    logic [SAMPLE_WIDTH-1:0] sample_out;
    logic                    done;

    int seed           = 7865;
    int assert_errors  = 0;      // raised from the bound assertions
    int timeout_errors = 0;
    int cycle_count    = 0;

    logic                    model_en_q;
    logic                    model_active;
    int                      model_k;         // beat number within the frame
    logic [DATA_SIZE-1:0]    model_word;
    logic                    s1_valid;
    logic                    s1_last;
    logic [SAMPLE_WIDTH-1:0] s1_sample;
    int                      s1_pos;
    logic                    out_valid;
    logic [SAMPLE_WIDTH-1:0] exp_sample;
    logic                    exp_done;
    int                      out_pos;

    logic                    record_zero;
    logic                    pair_check;
    logic [SAMPLE_WIDTH-1:0] zero_frame [FRAME_BEATS];
    logic [SAMPLE_WIDTH-1:0] mirror_sample;

    bpsk_modulator #(
        .DATA_SIZE(DATA_SIZE)
    ) i_bpsk_modulator (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .data      (data),
        .sample_out(sample_out),
        .done      (done)
    );

    bind bpsk_modulator bpsk_modulator_properties i_bpsk_modulator_properties (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (enable),
        .sample_out(sample_out),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // a 1 bit shifts the carrier by half a period, rounding is symmetric around zero
    function automatic logic [SAMPLE_WIDTH-1:0] model_level(input logic data_bit, input int idx);
        real angle;
        real scaled;
        int  rounded;
        angle  = 2.0 * PI * real'(idx + (data_bit ? SAMPLES_PER_BIT / 2 : 0))
                 / real'(SAMPLES_PER_BIT);
        scaled = real'(PEAK) * $sin(angle);
        if (scaled >= 0.0) begin
            rounded = $rtoi(scaled + 0.5);
        end else begin
            rounded = -$rtoi(0.5 - scaled);
        end
        return SAMPLE_WIDTH'(int'(MIDSCALE) + rounded);
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            model_en_q   <= 1'b0;
            model_active <= 1'b0;
            model_k      <= 0;
            s1_valid     <= 1'b0;
            s1_last      <= 1'b0;
            s1_sample    <= MIDSCALE;
            out_valid    <= 1'b0;
            exp_sample   <= MIDSCALE;
            exp_done     <= 1'b0;
        end else begin
            model_en_q <= enable;
            if (enable && !model_en_q) begin
                model_active <= 1'b1;
                model_k      <= 0;
                model_word   <= data;
            end else if (model_active) begin
                if (!enable || model_k == FRAME_BEATS - 1) begin
                    model_active <= 1'b0;
                end else begin
                    model_k <= model_k + 1;
                end
            end
            // bits go out MSB first, 64 samples each
            s1_valid  <= model_active;
            s1_last   <= model_active && (model_k == FRAME_BEATS - 1);
            s1_sample <= model_active ?
                model_level(model_word[DATA_SIZE - 1 - model_k / SAMPLES_PER_BIT],
                            model_k % SAMPLES_PER_BIT) : MIDSCALE;
            s1_pos    <= model_k;
            out_valid  <= s1_valid;
            exp_sample <= s1_sample;
            exp_done   <= s1_valid && s1_last;
            out_pos    <= s1_pos;
        end
    end

    always @(posedge clk) begin
        if (record_zero && out_valid) begin
            zero_frame[out_pos] <= sample_out;   // all-zeros word, compared against all-ones
        end
    end

    assign mirror_sample = zero_frame[out_pos];

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            timeout_errors = 1;
            $display("timeout after %0d cycles without reaching the end of the tests",
                     cycle_count);
            $display("assertion errors: %0d, timeouts: %0d", assert_errors, timeout_errors);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic next_cycle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic start_frame(input logic [DATA_SIZE-1:0] word);
        data   = word;
        enable = 1'b1;
    endtask

    task automatic wait_for_done();
        next_cycle(1);
        while (!done) begin
            next_cycle(1);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        enable      = 1'b0;
        data        = '0;
        record_zero = 1'b0;
        pair_check  = 1'b0;
        next_cycle(4);
        rst_n = 1'b1;
        next_cycle(10);

        // enable stays high past the end, so no second frame may start
        start_frame(DATA_SIZE'($random(seed)));
        wait_for_done();
        next_cycle(20);
        enable = 1'b0;
        next_cycle(5);

        start_frame(DATA_SIZE'($random(seed)));   // fresh edge, fresh word
        wait_for_done();
        next_cycle(1);
        enable = 1'b0;
        next_cycle(10);

        start_frame(DATA_SIZE'($random(seed)));
        next_cycle(ABORT_CYCLES);
        enable = 1'b0;                            // abort partway through bit 2
        next_cycle(10);

        record_zero = 1'b1;
        start_frame('0);
        wait_for_done();
        next_cycle(1);
        record_zero = 1'b0;
        enable      = 1'b0;
        next_cycle(5);

        pair_check = 1'b1;
        start_frame('1);
        wait_for_done();
        next_cycle(1);
        pair_check = 1'b0;
        enable     = 1'b0;
        next_cycle(10);

        $display("assertion errors: %0d, timeouts: %0d", assert_errors, timeout_errors);
        if (assert_errors + timeout_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/bpsk_pkg.sv
rtl/frame_sequencer.sv
rtl/phase_mapper.sv
rtl/sine_lookup.sv
rtl/bpsk_modulator.sv
dv/bpsk_modulator_properties.sv
dv/bpsk_modulator_tb.sv

//--- run.sh
#!/bin/sh
# builds the BPSK modulator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module bpsk_modulator_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# keep running past assertion failures so the testbench prints its own summary
./obj_dir/Vbpsk_modulator_tb +verilator+error+limit+100000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
exit 0
